// ==== src/rtc_settings.svh ====
// RTC core build settings
// Second divider width and the BCD values that counters take at reset
// Shared by the tick generator, both counters and the top level

`ifndef RTC_SETTINGS_SVH
`define RTC_SETTINGS_SVH

//----------------------------------------------------------------------
// Second divider
//----------------------------------------------------------------------

// 2^15 cycles of the 32768 Hz clock make one second
// Default for rtc_core and rtc_tick_gen div_bits, shrink it for simulation
`define RTC_DIV_BITS 15

//----------------------------------------------------------------------
// Reset values
//----------------------------------------------------------------------

// Day of week starts at 1 and runs to 7
`define RTC_DOW_FIRST 1

// Day and month both start at 01
// Seconds, minutes, hours, year and century start at zero
`define RTC_DATE_FIRST 1

`endif

// ==== src/rtc_pkg.sv ====
// RTC shared types
// BCD digit, DS3231 style register byte and the two views of the hour byte

package rtc_pkg;

	//------------------------------------------------------------------
	// Basic fields
	//------------------------------------------------------------------

	typedef logic [3:0] bcd_t;      // One BCD digit, 0 to 9

	// Register byte as in the DS3231 map
	// Seconds, minutes, day of week, day, month, year, century
	typedef logic [7:0] rtc_byte_t;

	//------------------------------------------------------------------
	// Hour register
	//------------------------------------------------------------------

	// 24-hour view, 00 to 23
	typedef struct packed {
		logic       zero;       // Always 0
		logic       mode;       // 0 here
		logic [1:0] ten_hour;   // Tens of hours, 0 to 2
		bcd_t       hour;       // Units of hours
	} hour_24_t;

	// 12-hour view, 12 AM then 1 to 11, PM flag in bit 5
	typedef struct packed {
		logic zero;             // Always 0
		logic mode;             // 1 here
		logic pm;               // Set for PM
		logic ten_hour;         // Tens of hours, 0 or 1
		bcd_t hour;             // Units of hours
	} hour_12_t;

	// Bit 5 is either a tens bit or the PM flag
	// The mode input picks the view
	typedef union packed {
		hour_24_t h24;
		hour_12_t h12;
	} hour_reg_t;

endpackage

// ==== src/rtc_tick_gen.sv ====
// RTC second tick generator
// Free running divider on the RTC clock
// Registers the all-ones state of the divider as a one-cycle second tick
// Update or divider clear restart the count, halt freezes it

`timescale 1ns/1ps

`include "rtc_settings.svh"

module rtc_tick_gen #(
	parameter int div_bits = `RTC_DIV_BITS   // 15 for a 32768 Hz clock
) (
	input  logic rtc_clk,
	input  logic rst_n,
	input  logic cfg_update,      // Time/date load strobe
	input  logic cfg_div_clear,   // Divider restart strobe
	input  logic cfg_halt,        // Stop counting
	output logic sec_tick         // One cycle per second
);

	logic [div_bits-1:0] div_cnt;   // Cycle count within the second

	//------------------------------------------------------------------
	// Divider and tick register
	//------------------------------------------------------------------

	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt  <= '0;
			sec_tick <= 1'b0;
		end else if (cfg_update || cfg_div_clear) begin
			// New time loaded or software restart
			div_cnt  <= '0;
			sec_tick <= 1'b0;
		end else if (!cfg_halt) begin
			div_cnt  <= div_cnt + 1'b1;
			sec_tick <= &div_cnt;     // Last cycle of the second
		end else begin
			// Halted, divider holds and a pending tick is dropped
			sec_tick <= 1'b0;
		end
	end

	//------------------------------------------------------------------
	// Checks
	//------------------------------------------------------------------

	// Counters downstream advance once per pulse
	a_tick_single: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		sec_tick |=> !sec_tick);

endmodule

// ==== src/rtc_time_counter.sv ====
// RTC time of day counter
// BCD seconds, minutes and hours with 24-hour or 12-hour AM/PM roll-over
// Day of week runs 1 to 7 and steps at midnight
// day_tick flags the midnight roll-over to the date counter in the same cycle

`timescale 1ns/1ps

`include "rtc_settings.svh"

module rtc_time_counter
	import rtc_pkg::*;
(
	input  logic        rtc_clk,
	input  logic        rst_n,
	input  logic        cfg_update,   // Load strobe
	input  logic        cfg_hmode,    // 1 for 12-hour mode
	input  logic [31:0] cfg_time,     // Sec, min, hour, dow bytes
	input  logic        sec_tick,
	output rtc_byte_t   time_sec,
	output rtc_byte_t   time_min,
	output hour_reg_t   time_hour,
	output rtc_byte_t   time_dow,
	output logic        day_tick      // Midnight, combinational
);

	bcd_t       sec_u;        // Seconds
	logic [2:0] sec_t;        // Ten seconds
	bcd_t       min_u;        // Minutes
	logic [2:0] min_t;        // Ten minutes
	bcd_t       hour_u;       // Hours
	logic [1:0] hour_t;       // Ten hours
	logic       pm;           // PM flag, 12-hour mode only
	logic [2:0] dow;          // Day of week
	hour_reg_t  cfg_hour;     // Hour byte of the load word
	logic       sec_wrap;     // Carry chain
	logic       tsec_wrap;
	logic       min_wrap;
	logic       hour_inc;     // End of an hour
	logic       hour_last;    // Last hour before digits restart
	logic       pm_flip;      // 11 to 12 in 12-hour mode
	logic       zero_hour;    // Reset state, reads as 12 AM

	assign cfg_hour = cfg_time[23:16];

	//------------------------------------------------------------------
	// Carry chain
	//------------------------------------------------------------------

	assign sec_wrap  = sec_tick && sec_u == 4'd9;
	assign tsec_wrap = sec_wrap && sec_t == 3'd5;
	assign min_wrap  = tsec_wrap && min_u == 4'd9;
	assign hour_inc  = min_wrap && min_t == 3'd5;

	assign hour_last = cfg_hmode ? (hour_t == 2'd1 && hour_u == 4'd2)   // 12 to 01
	                             : (hour_t == 2'd2 && hour_u == 4'd3);  // 23 to 00
	assign pm_flip   = cfg_hmode && hour_t == 2'd1 && hour_u == 4'd1;
	assign day_tick  = hour_inc && (cfg_hmode ? (pm_flip && pm) : hour_last);

	// Seconds and minutes
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_u <= '0;
			sec_t <= '0;
			min_u <= '0;
			min_t <= '0;
		end else if (cfg_update) begin
			sec_u <= cfg_time[3:0];
			sec_t <= cfg_time[6:4];
			min_u <= cfg_time[11:8];
			min_t <= cfg_time[14:12];
		end else if (sec_tick) begin
			sec_u <= sec_wrap ? 4'd0 : sec_u + 4'd1;
			if (sec_wrap)
				sec_t <= tsec_wrap ? 3'd0 : sec_t + 3'd1;
			if (tsec_wrap)
				min_u <= min_wrap ? 4'd0 : min_u + 4'd1;
			if (min_wrap)
				min_t <= hour_inc ? 3'd0 : min_t + 3'd1;
		end
	end

	// Hours and PM flag
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			hour_u <= '0;
			hour_t <= '0;
			pm     <= 1'b0;
		end else if (cfg_update) begin
			hour_u <= cfg_hour.h24.hour;          // Same place in both views
			if (cfg_hmode) begin
				hour_t <= {1'b0, cfg_hour.h12.ten_hour};
				pm     <= cfg_hour.h12.pm;
			end else begin
				hour_t <= cfg_hour.h24.ten_hour;
				pm     <= 1'b0;
			end
		end else if (hour_inc) begin
			if (hour_last) begin
				hour_t <= 2'd0;
				hour_u <= cfg_hmode ? 4'd1 : 4'd0;   // 12-hour restarts at 01
			end else if (hour_u == 4'd9) begin
				hour_t <= hour_t + 2'd1;
				hour_u <= 4'd0;
			end else begin
				hour_u <= hour_u + 4'd1;
			end
			if (pm_flip)
				pm <= ~pm;                         // Noon and midnight
		end
	end

	// Day of week, 7 wraps to 1
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n)
			dow <= 3'(`RTC_DOW_FIRST);
		else if (cfg_update)
			dow <= cfg_time[26:24];
		else if (day_tick)
			dow <= (dow == 3'd7) ? 3'd1 : dow + 3'd1;
	end

	//------------------------------------------------------------------
	// Register view
	//------------------------------------------------------------------

	assign zero_hour = hour_t == 2'd0 && hour_u == 4'd0;

	assign time_sec = {1'b0, sec_t, sec_u};
	assign time_min = {1'b0, min_t, min_u};
	assign time_dow = {5'b0, dow};

	always_comb begin
		time_hour = '0;
		if (cfg_hmode) begin
			time_hour.h12.mode     = 1'b1;
			time_hour.h12.pm       = pm;
			time_hour.h12.ten_hour = zero_hour | hour_t[0];
			time_hour.h12.hour     = zero_hour ? 4'd2 : hour_u;
		end else begin
			time_hour.h24.ten_hour = hour_t;
			time_hour.h24.hour     = hour_u;
		end
	end

	//------------------------------------------------------------------
	// Checks
	//------------------------------------------------------------------

	a_bcd_digits: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		sec_u <= 4'd9 && sec_t <= 3'd5 && min_u <= 4'd9 && min_t <= 3'd5 &&
		hour_u <= 4'd9);

	// Counting only from a legal hour of the active mode
	a_hour_range: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		sec_tick |-> (cfg_hmode ? (hour_t == 2'd0 || (hour_t == 2'd1 && hour_u <= 4'd2))
		                        : (hour_t <= 2'd1 || (hour_t == 2'd2 && hour_u <= 4'd3))));

endmodule

// ==== src/rtc_date_counter.sv ====
// RTC calendar counter
// BCD day, month, year and century advanced by the midnight day_tick
// Month length from the month and a Gregorian leap flag
// Year 99 carries into the century, century 99 wraps to 00

`timescale 1ns/1ps

`include "rtc_settings.svh"

module rtc_date_counter
	import rtc_pkg::*;
(
	input  logic        rtc_clk,
	input  logic        rst_n,
	input  logic        cfg_update,   // Load strobe
	input  logic [31:0] cfg_date,     // Day, month, year, century bytes
	input  logic        day_tick,     // Midnight from the time counter
	output rtc_byte_t   date_day,
	output rtc_byte_t   date_month,
	output rtc_byte_t   date_year,
	output rtc_byte_t   date_century
);

	bcd_t       day_u;        // Day of month
	logic [1:0] day_t;        // Ten days
	bcd_t       mon_u;        // Month
	logic       mon_t;        // Ten months
	bcd_t       year_u;       // Year
	bcd_t       year_t;       // Ten years
	bcd_t       cent_u;       // Century
	bcd_t       cent_t;       // Ten centuries
	rtc_byte_t  day_bcd;
	rtc_byte_t  month_bcd;
	rtc_byte_t  month_len;    // Last day of current month, BCD
	logic       leap_year;
	logic       month_inc;    // Last day of month at midnight
	logic       year_inc;     // 31 December at midnight
	logic       cent_inc;     // Year 99 rolls over

	// Two digit BCD number divisible by 4
	// Even tens need units 0/4/8, odd tens need 2/6
	function automatic logic bcd_div4(input bcd_t tens, input bcd_t units);
		logic odd_tens;
		odd_tens = tens[0];
		if (odd_tens)
			return units == 4'd2 || units == 4'd6;
		return units == 4'd0 || units == 4'd4 || units == 4'd8;
	endfunction

	assign day_bcd   = {2'b00, day_t, day_u};
	assign month_bcd = {3'b000, mon_t, mon_u};

	//------------------------------------------------------------------
	// Leap year and month length
	//------------------------------------------------------------------

	// Years xx00 need the century divisible by 4 (1900 no, 2000 yes)
	assign leap_year = (year_t == 4'd0 && year_u == 4'd0) ? bcd_div4(cent_t, cent_u)
	                                                      : bcd_div4(year_t, year_u);

	always_comb begin
		case (month_bcd)
			8'h02:                      month_len = leap_year ? 8'h29 : 8'h28;
			8'h04, 8'h06, 8'h09, 8'h11: month_len = 8'h30;
			default:                    month_len = 8'h31;
		endcase
	end

	assign month_inc = day_tick && day_bcd == month_len;
	assign year_inc  = month_inc && month_bcd == 8'h12;
	assign cent_inc  = year_inc && year_t == 4'd9 && year_u == 4'd9;

	//------------------------------------------------------------------
	// Counters
	//------------------------------------------------------------------

	// Day, restarts at 01
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			day_u <= 4'(`RTC_DATE_FIRST);
			day_t <= '0;
		end else if (cfg_update) begin
			day_u <= cfg_date[3:0];
			day_t <= cfg_date[5:4];
		end else if (month_inc) begin
			day_u <= 4'd1;
			day_t <= 2'd0;
		end else if (day_tick) begin
			if (day_u == 4'd9) begin
				day_u <= 4'd0;
				day_t <= day_t + 2'd1;
			end else begin
				day_u <= day_u + 4'd1;
			end
		end
	end

	// Month, 12 to 01
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			mon_u <= 4'(`RTC_DATE_FIRST);
			mon_t <= 1'b0;
		end else if (cfg_update) begin
			mon_u <= cfg_date[11:8];
			mon_t <= cfg_date[12];
		end else if (year_inc) begin
			mon_u <= 4'd1;
			mon_t <= 1'b0;
		end else if (month_inc) begin
			if (mon_u == 4'd9) begin       // September to October
				mon_u <= 4'd0;
				mon_t <= 1'b1;
			end else begin
				mon_u <= mon_u + 4'd1;
			end
		end
	end

	// Year 00 to 99
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			year_u <= '0;
			year_t <= '0;
		end else if (cfg_update) begin
			year_u <= cfg_date[19:16];
			year_t <= cfg_date[23:20];
		end else if (year_inc) begin
			if (year_u == 4'd9) begin
				year_u <= 4'd0;
				year_t <= (year_t == 4'd9) ? 4'd0 : year_t + 4'd1;
			end else begin
				year_u <= year_u + 4'd1;
			end
		end
	end

	// Century 00 to 99, then wraps
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			cent_u <= '0;
			cent_t <= '0;
		end else if (cfg_update) begin
			cent_u <= cfg_date[27:24];
			cent_t <= cfg_date[31:28];
		end else if (cent_inc) begin
			if (cent_u == 4'd9) begin
				cent_u <= 4'd0;
				cent_t <= (cent_t == 4'd9) ? 4'd0 : cent_t + 4'd1;
			end else begin
				cent_u <= cent_u + 4'd1;
			end
		end
	end

	assign date_day     = day_bcd;
	assign date_month   = month_bcd;
	assign date_year    = {year_t, year_u};
	assign date_century = {cent_t, cent_u};

	//------------------------------------------------------------------
	// Checks
	//------------------------------------------------------------------

	// Day 01 up to the length of the current month and year
	a_day_in_month: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		day_bcd != 8'h00 && day_bcd <= month_len);

endmodule

// ==== src/rtc_core.sv ====
// RTC core top level
// Second tick generator feeding the time of day counter
// Midnight carry from the time counter feeds the calendar counter
// Whole carry from seconds to century settles in one clock edge

`timescale 1ns/1ps

`include "rtc_settings.svh"

module rtc_core
	import rtc_pkg::*;
#(
	parameter int div_bits = `RTC_DIV_BITS   // Second divider width
) (
	input  logic        rtc_clk,
	input  logic        rst_n,
	input  logic        cfg_update,      // Load time and date
	input  logic        cfg_halt,        // Stop counting
	input  logic        cfg_div_clear,   // Restart the second
	input  logic        cfg_hmode,       // 1 for 12-hour mode
	input  logic [31:0] cfg_time,
	input  logic [31:0] cfg_date,
	output rtc_byte_t   time_sec,
	output rtc_byte_t   time_min,
	output hour_reg_t   time_hour,
	output rtc_byte_t   time_dow,
	output rtc_byte_t   date_day,
	output rtc_byte_t   date_month,
	output rtc_byte_t   date_year,
	output rtc_byte_t   date_century
);

	logic sec_tick;   // One cycle per second
	logic day_tick;   // Midnight roll-over

	rtc_tick_gen #(
		.div_bits      (div_bits)
	) u_tick (
		.rtc_clk       (rtc_clk),
		.rst_n         (rst_n),
		.cfg_update    (cfg_update),
		.cfg_div_clear (cfg_div_clear),
		.cfg_halt      (cfg_halt),
		.sec_tick      (sec_tick)
	);

	rtc_time_counter u_time (
		.rtc_clk    (rtc_clk),
		.rst_n      (rst_n),
		.cfg_update (cfg_update),
		.cfg_hmode  (cfg_hmode),
		.cfg_time   (cfg_time),
		.sec_tick   (sec_tick),
		.time_sec   (time_sec),
		.time_min   (time_min),
		.time_hour  (time_hour),
		.time_dow   (time_dow),
		.day_tick   (day_tick)
	);

	rtc_date_counter u_date (
		.rtc_clk      (rtc_clk),
		.rst_n        (rst_n),
		.cfg_update   (cfg_update),
		.cfg_date     (cfg_date),
		.day_tick     (day_tick),
		.date_day     (date_day),
		.date_month   (date_month),
		.date_year    (date_year),
		.date_century (date_century)
	);

endmodule

// ==== verif/tb_rtc_core.sv ====
// RTC core testbench
// Directed tests for reset, loading, second counting with halt,
// 24-hour and 12-hour roll-over, leap years and divider clear
// Inputs change and outputs are sampled on the falling clock edge

`timescale 1ns/1ps

`include "rtc_settings.svh"

module tb_rtc_core
	import rtc_pkg::*;
#(
	parameter int div_bits = `RTC_DIV_BITS   // Shrunk by the Makefile
) ();

	localparam int tick_cycles = 1 << div_bits;   // Clock cycles per second
	localparam int rand_years  = 4;

	// Tick periods waited by all tests plus one for reset and loads
	localparam int waited_periods = 1 + 9 + 1 + 2 + (4 + rand_years) + 2;
	localparam longint watchdog_ns = longint'(2) * waited_periods * tick_cycles * 40;

	logic        rtc_clk = 1'b0;
	logic        rst_n;
	logic        cfg_update;
	logic        cfg_halt;
	logic        cfg_div_clear;
	logic        cfg_hmode;
	logic [31:0] cfg_time;
	logic [31:0] cfg_date;
	rtc_byte_t   time_sec;
	rtc_byte_t   time_min;
	hour_reg_t   time_hour;
	rtc_byte_t   time_dow;
	rtc_byte_t   date_day;
	rtc_byte_t   date_month;
	rtc_byte_t   date_year;
	rtc_byte_t   date_century;

	int byte_errors = 0;   // Wrong register bytes
	int hour_errors = 0;   // Wrong hour words

	always #20 rtc_clk = ~rtc_clk;   // 40 ns period

	rtc_core #(
		.div_bits (div_bits)
	) u_dut (
		.rtc_clk       (rtc_clk),
		.rst_n         (rst_n),
		.cfg_update    (cfg_update),
		.cfg_halt      (cfg_halt),
		.cfg_div_clear (cfg_div_clear),
		.cfg_hmode     (cfg_hmode),
		.cfg_time      (cfg_time),
		.cfg_date      (cfg_date),
		.time_sec      (time_sec),
		.time_min      (time_min),
		.time_hour     (time_hour),
		.time_dow      (time_dow),
		.date_day      (date_day),
		.date_month    (date_month),
		.date_year     (date_year),
		.date_century  (date_century)
	);

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------

	function automatic rtc_byte_t to_bcd(input int value);
		return {4'(value / 10), 4'(value % 10)};   // Two BCD digits for 0 to 99
	endfunction

	// Gregorian rule on the full four-digit year
	function automatic logic is_leap(input int year);
		return (year % 4 == 0 && year % 100 != 0) || year % 400 == 0;
	endfunction

	task automatic check_byte(input string name, input rtc_byte_t expected,
	                          input rtc_byte_t actual);
		if (actual !== expected) begin
			byte_errors++;
			$display("Mismatch at %0t: %s expected %02h actual %02h",
			         $time, name, expected, actual);
		end
	endtask

	task automatic check_hour(input string name, input hour_reg_t expected,
	                          input hour_reg_t actual);
		if (actual !== expected) begin
			hour_errors++;
			$display("Mismatch at %0t: %s expected %02h actual %02h",
			         $time, name, expected, actual);
		end
	endtask

	task automatic expect_time(input rtc_byte_t sec, input rtc_byte_t min,
	                           input hour_reg_t hour, input rtc_byte_t dow);
		check_byte("time_sec", sec, time_sec);
		check_byte("time_min", min, time_min);
		check_hour("time_hour", hour, time_hour);
		check_byte("time_dow", dow, time_dow);
	endtask

	task automatic expect_date(input rtc_byte_t day, input rtc_byte_t month,
	                           input rtc_byte_t year, input rtc_byte_t century);
		check_byte("date_day", day, date_day);
		check_byte("date_month", month, date_month);
		check_byte("date_year", year, date_year);
		check_byte("date_century", century, date_century);
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) @(negedge rtc_clk);
	endtask

	// One-cycle update strobe starting on a falling edge
	task automatic load_regs(input logic [31:0] time_word, input logic [31:0] date_word,
	                         input logic hmode);
		cfg_time   = time_word;
		cfg_date   = date_word;
		cfg_hmode  = hmode;
		cfg_update = 1'b1;
		@(negedge rtc_clk);
		cfg_update = 1'b0;
	endtask

	//----------------------------------------------------------------------
	// Tests
	//----------------------------------------------------------------------

	task automatic reset_and_load();
		expect_time(8'h00, 8'h00, 8'h00, 8'h01);   // Straight out of reset
		expect_date(8'h01, 8'h01, 8'h00, 8'h00);
		cfg_hmode = 1'b1;
		@(negedge rtc_clk);
		check_hour("time_hour 12h reset", 8'h52, time_hour);   // 12 AM
		load_regs(32'h03_15_42_37, 32'h20_25_07_19, 1'b0);
		expect_time(8'h37, 8'h42, 8'h15, 8'h03);
		expect_date(8'h19, 8'h07, 8'h25, 8'h20);
		load_regs(32'h05_71_08_26, 32'h19_87_11_30, 1'b1);     // 11 PM
		expect_time(8'h26, 8'h08, 8'h71, 8'h05);
		expect_date(8'h30, 8'h11, 8'h87, 8'h19);
	endtask

	task automatic count_seconds_and_halt();
		int start_sec;
		int steps;
		start_sec = $urandom_range(49, 0);
		steps     = 5;
		load_regs({8'h02, 8'h08, 8'h10, to_bcd(start_sec)}, 32'h20_24_03_14, 1'b0);
		wait_cycles(steps * tick_cycles + 2);
		check_byte("time_sec counting", to_bcd(start_sec + steps), time_sec);
		cfg_halt = 1'b1;                    // Frozen for three periods
		wait_cycles(3 * tick_cycles);
		check_byte("time_sec halted", to_bcd(start_sec + steps), time_sec);
		cfg_halt = 1'b0;
		wait_cycles(tick_cycles + 2);       // Held divider finishes its second
		check_byte("time_sec resumed", to_bcd(start_sec + steps + 1), time_sec);
		check_byte("time_min", 8'h10, time_min);
	endtask

	task automatic midnight_carry_24h();
		load_regs(32'h07_23_59_59, 32'h19_99_12_31, 1'b0);
		wait_cycles(tick_cycles + 2);
		expect_time(8'h00, 8'h00, 8'h00, 8'h01);
		expect_date(8'h01, 8'h01, 8'h00, 8'h20);   // Carry into the century
	endtask

	task automatic noon_midnight_12h();
		load_regs(32'h03_51_59_59, 32'h20_21_06_15, 1'b1);   // 11:59:59 AM
		wait_cycles(tick_cycles + 2);
		expect_time(8'h00, 8'h00, 8'h72, 8'h03);              // 12 PM on the same day
		expect_date(8'h15, 8'h06, 8'h21, 8'h20);
		load_regs(32'h03_71_59_59, 32'h20_21_06_15, 1'b1);   // 11:59:59 PM
		wait_cycles(tick_cycles + 2);
		expect_time(8'h00, 8'h00, 8'h52, 8'h04);              // 12 AM on the next day
		expect_date(8'h16, 8'h06, 8'h21, 8'h20);
	endtask

	task automatic leap_year_february();
		int years[$];
		int year;
		years = '{2024, 2023, 1900, 2000};
		repeat (rand_years)
			years.push_back($urandom_range(9999, 0));
		foreach (years[i]) begin
			year = years[i];
			load_regs(32'h01_23_59_59, {to_bcd(year / 100), to_bcd(year % 100), 16'h02_28},
			          1'b0);
			wait_cycles(tick_cycles + 2);
			if (is_leap(year))
				expect_date(8'h29, 8'h02, to_bcd(year % 100), to_bcd(year / 100));
			else
				expect_date(8'h01, 8'h03, to_bcd(year % 100), to_bcd(year / 100));
		end
	endtask

	task automatic divider_clear_restart();
		load_regs(32'h04_12_30_10, 32'h20_24_09_01, 1'b0);
		wait_cycles(tick_cycles / 2);       // Midway through the second
		cfg_div_clear = 1'b1;
		@(negedge rtc_clk);
		cfg_div_clear = 1'b0;
		wait_cycles(tick_cycles - 1);       // Old tick would be long past
		check_byte("time_sec before restart tick", 8'h10, time_sec);
		wait_cycles(3);
		check_byte("time_sec after restart tick", 8'h11, time_sec);
	endtask

	//----------------------------------------------------------------------
	// Sequence and watchdog
	//----------------------------------------------------------------------

	initial begin
		rst_n         = 1'b0;
		cfg_update    = 1'b0;
		cfg_halt      = 1'b0;
		cfg_div_clear = 1'b0;
		cfg_hmode     = 1'b0;
		cfg_time      = '0;
		cfg_date      = '0;
		void'($urandom(69731));
		repeat (5) @(negedge rtc_clk);
		rst_n = 1'b1;
		reset_and_load();
		count_seconds_and_halt();
		midnight_carry_24h();
		noon_midnight_12h();
		leap_year_february();
		divider_clear_restart();
		$display("Errors: %0d byte mismatches, %0d hour mismatches",
		         byte_errors, hour_errors);
		if (byte_errors + hour_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout after %0d ns, the tests did not complete", watchdog_ns);
		$display("sim failed");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+src
src/rtc_pkg.sv
src/rtc_tick_gen.sv
src/rtc_time_counter.sv
src/rtc_date_counter.sv
src/rtc_core.sv
verif/tb_rtc_core.sv

// ==== Makefile ====
# Verilator build and run of the RTC core testbench
# Override any variable on the command line, e.g. make DIV_BITS=8

VERILATOR ?= verilator
TOP       ?= tb_rtc_core
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
DIV_BITS  ?= 6
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -Gdiv_bits=$(DIV_BITS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "PASS: $(TOP)"; \
	else \
		echo "FAIL: $(TOP), see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing -Gdiv_bits=$(DIV_BITS) \
		-f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
